// File: hdl/ecc_pkg.sv
package ecc_pkg;

    // field element width
    localparam int FIELD_W = 32;

    typedef logic [FIELD_W-1:0] field_t;

    // codes as seen by the arithmetic unit
    typedef enum logic [1:0]
    {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2,
        OP_DIV = 2'd3
    } op_code_t;

    // affine point, x in the upper half
    typedef struct packed
    {
        field_t x;
        field_t y;
    } point_t;

    // micro-sequence lengths
    localparam int DBL_STEPS = 12;
    localparam int ADD_STEPS = 9;

    // step counter width, sized for the longer sequence
    localparam int STEP_W = $clog2(DBL_STEPS);

endpackage

// File: hdl/field_op_if.sv
`timescale 1ns/1ps

interface field_op_if;
    import ecc_pkg::*;

    logic     req;  // one-cycle operation request
    op_code_t op;
    field_t   a;
    field_t   b;
    logic     rsp;  // one-cycle result strobe
    field_t   res;

    modport seq
    (
        output req, op, a, b,
        input  rsp, res
    );

    modport port
    (
        input  req, op, a, b,
        output rsp, res
    );

endinterface

// File: hdl/key_scanner.sv
`timescale 1ns/1ps

module key_scanner
#(
    parameter int KEY_BITS = 8
)
(
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                load,
    input  logic                next,
    input  logic [KEY_BITS-1:0] key,
    output logic                key_bit,
    output logic                last_bit
);

    localparam int CNT_W = $clog2(KEY_BITS);

    logic [KEY_BITS-2:0] key_sh;   // remaining bits, current one on top
    logic [CNT_W-1:0]    bit_cnt;  // index of the current bit

    always_ff @(posedge i_clk or negedge i_reset)
    begin
        if (!i_reset)
        begin
            key_sh  <= '0;
            bit_cnt <= '0;
        end
        else if (load)
        begin
            key_sh  <= key[KEY_BITS-2:0];  // top bit is always 1, Q starts as P
            bit_cnt <= CNT_W'(KEY_BITS - 2);
        end
        else if (next)
        begin
            key_sh  <= key_sh << 1;
            bit_cnt <= bit_cnt - 1'b1;
        end
    end

    assign key_bit  = key_sh[KEY_BITS-2];
    assign last_bit = (bit_cnt == '0);

endmodule

// File: hdl/point_op_sequencer.sv
`timescale 1ns/1ps

module point_op_sequencer
(
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic            start,
    input  logic            key_bit,
    input  logic            last_bit,
    input  ecc_pkg::point_t base,
    input  ecc_pkg::field_t curve_a,
    output logic            load,
    output logic            next,
    output logic            busy,
    output logic            done,
    output ecc_pkg::point_t result,
    field_op_if.seq         ops
);
    import ecc_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT} state_t;
    typedef enum logic [2:0] {D_T, D_U, D_L, D_X3, D_Q} dest_t;

    state_t            state;
    logic              is_add;  // in the addition sequence
    logic [STEP_W-1:0] step;
    dest_t             dest;
    logic              last_step;
    logic              rsp_hit;

    point_t q;       // running point
    point_t p2;      // latched base point
    field_t coef_a;
    field_t t;
    field_t u;
    field_t l;
    field_t x3;

    assign busy    = (state != S_IDLE);
    assign load    = start && !busy;
    assign rsp_hit = (state == S_WAIT) && ops.rsp;
    assign result  = q;
    assign ops.req = (state == S_REQ);

    assign last_step = is_add ? (step == STEP_W'(ADD_STEPS - 1))
                              : (step == STEP_W'(DBL_STEPS - 1));

    // bit ends after doubling with a 0 bit or after the addition
    assign next = rsp_hit && last_step && (is_add || !key_bit);

    // operand and destination decode
    always_comb
    begin
        ops.op = OP_ADD;
        ops.a  = '0;
        ops.b  = '0;
        dest   = D_T;
        if (!is_add)
        begin
            case (step)
                4'd0:  begin ops.op = OP_MUL; ops.a = q.x; ops.b = q.x;    dest = D_T;  end
                4'd1:  begin ops.op = OP_ADD; ops.a = t;   ops.b = t;      dest = D_U;  end
                4'd2:  begin ops.op = OP_ADD; ops.a = u;   ops.b = t;      dest = D_T;  end
                4'd3:  begin ops.op = OP_ADD; ops.a = t;   ops.b = coef_a; dest = D_T;  end
                4'd4:  begin ops.op = OP_ADD; ops.a = q.y; ops.b = q.y;    dest = D_U;  end
                4'd5:  begin ops.op = OP_DIV; ops.a = t;   ops.b = u;      dest = D_L;  end
                4'd6:  begin ops.op = OP_MUL; ops.a = l;   ops.b = l;      dest = D_T;  end
                4'd7:  begin ops.op = OP_SUB; ops.a = t;   ops.b = q.x;    dest = D_T;  end
                4'd8:  begin ops.op = OP_SUB; ops.a = t;   ops.b = q.x;    dest = D_X3; end
                4'd9:  begin ops.op = OP_SUB; ops.a = q.x; ops.b = x3;     dest = D_U;  end
                4'd10: begin ops.op = OP_MUL; ops.a = l;   ops.b = u;      dest = D_U;  end
                default:
                begin
                    ops.op = OP_SUB;  // y3 = u - y
                    ops.a  = u;
                    ops.b  = q.y;
                    dest   = D_Q;
                end
            endcase
        end
        else
        begin
            case (step)
                4'd0:  begin ops.op = OP_SUB; ops.a = p2.x; ops.b = q.x;  dest = D_T;  end
                4'd1:  begin ops.op = OP_SUB; ops.a = p2.y; ops.b = q.y;  dest = D_U;  end
                4'd2:  begin ops.op = OP_DIV; ops.a = u;    ops.b = t;    dest = D_L;  end
                4'd3:  begin ops.op = OP_MUL; ops.a = l;    ops.b = l;    dest = D_T;  end
                4'd4:  begin ops.op = OP_SUB; ops.a = t;    ops.b = q.x;  dest = D_T;  end
                4'd5:  begin ops.op = OP_SUB; ops.a = t;    ops.b = p2.x; dest = D_X3; end
                4'd6:  begin ops.op = OP_SUB; ops.a = q.x;  ops.b = x3;   dest = D_U;  end
                4'd7:  begin ops.op = OP_MUL; ops.a = l;    ops.b = u;    dest = D_U;  end
                default:
                begin
                    ops.op = OP_SUB;
                    ops.a  = u;
                    ops.b  = q.y;
                    dest   = D_Q;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_reset)
    begin
        if (!i_reset)
        begin
            state  <= S_IDLE;
            is_add <= 1'b0;
            step   <= '0;
            done   <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (start)
                    begin
                        state  <= S_REQ;
                        is_add <= 1'b0;
                        step   <= '0;
                    end
                end
                S_REQ:
                begin
                    state <= S_WAIT;
                end
                default:
                begin
                    if (ops.rsp)
                    begin
                        if (!last_step)
                        begin
                            step  <= step + 1'b1;
                            state <= S_REQ;
                        end
                        else if (!is_add && key_bit)
                        begin
                            is_add <= 1'b1;  // bit is 1, add P
                            step   <= '0;
                            state  <= S_REQ;
                        end
                        else if (last_bit)
                        begin
                            state <= S_IDLE;
                            done  <= 1'b1;
                        end
                        else
                        begin
                            is_add <= 1'b0;
                            step   <= '0;
                            state  <= S_REQ;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (load)
        begin
            q      <= base;
            p2     <= base;
            coef_a <= curve_a;
        end
        else if (rsp_hit)
        begin
            case (dest)
                D_T:     t  <= ops.res;
                D_U:     u  <= ops.res;
                D_L:     l  <= ops.res;
                D_X3:    x3 <= ops.res;
                default: q  <= '{x: x3, y: ops.res};
            endcase
        end
    end

endmodule

// File: hdl/op_credit_port.sv
`timescale 1ns/1ps

module op_credit_port
(
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               res_valid,
    input  ecc_pkg::field_t    res_data,
    output logic               op_valid,
    output ecc_pkg::op_code_t  op_code,
    output ecc_pkg::field_t    op_a,
    output ecc_pkg::field_t    op_b,
    field_op_if.port           ops
);
    import ecc_pkg::*;

    logic credit;  // single outstanding operation
    logic issue;

    assign issue   = ops.req && credit;
    assign ops.rsp = res_valid && !credit;  // stray results dropped
    assign ops.res = res_data;

    always_ff @(posedge i_clk or negedge i_reset)
    begin
        if (!i_reset)
        begin
            credit   <= 1'b1;
            op_valid <= 1'b0;
        end
        else
        begin
            op_valid <= issue;
            if (issue)
                credit <= 1'b0;
            else if (ops.rsp)
                credit <= 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (issue)
        begin
            op_code <= op_code_t'(ops.op);
            op_a    <= ops.a;
            op_b    <= ops.b;
        end
    end

endmodule

// File: hdl/point_mult_top.sv
`timescale 1ns/1ps

module point_mult_top
#(
    parameter int KEY_BITS = 8
)
(
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               start,
    input  logic [KEY_BITS-1:0] key,
    input  ecc_pkg::field_t    px,
    input  ecc_pkg::field_t    py,
    input  ecc_pkg::field_t    curve_a,
    output logic               op_valid,
    output ecc_pkg::op_code_t  op_code,
    output ecc_pkg::field_t    op_a,
    output ecc_pkg::field_t    op_b,
    input  logic               res_valid,
    input  ecc_pkg::field_t    res_data,
    output logic               busy,
    output logic               done,
    output ecc_pkg::field_t    qx,
    output ecc_pkg::field_t    qy
);
    import ecc_pkg::*;

    logic   load;
    logic   next;
    logic   key_bit;
    logic   last_bit;
    point_t base;
    point_t result;

    field_op_if ops ();

    assign base = '{x: px, y: py};
    assign qx   = result.x;
    assign qy   = result.y;

    key_scanner #(.KEY_BITS(KEY_BITS)) key_scanner_inst
    (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .load     (load),
        .next     (next),
        .key      (key),
        .key_bit  (key_bit),
        .last_bit (last_bit)
    );

    point_op_sequencer point_op_sequencer_inst
    (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .start    (start),
        .key_bit  (key_bit),
        .last_bit (last_bit),
        .base     (base),
        .curve_a  (curve_a),
        .load     (load),
        .next     (next),
        .busy     (busy),
        .done     (done),
        .result   (result),
        .ops      (ops.seq)
    );

    op_credit_port op_credit_port_inst
    (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .res_valid (res_valid),
        .res_data  (res_data),
        .op_valid  (op_valid),
        .op_code   (op_code),
        .op_a      (op_a),
        .op_b      (op_b),
        .ops       (ops.port)
    );

endmodule

// File: sim/point_mult_assert.sv
`timescale 1ns/1ps

module point_mult_assert
(
    input logic i_clk,
    input logic i_reset,
    input logic op_valid,
    input logic res_valid,
    input logic busy,
    input logic done
);

    logic outstanding;  // issued, result not back yet

    always_ff @(posedge i_clk or negedge i_reset)
    begin
        if (!i_reset)
            outstanding <= 1'b0;
        else if (op_valid)
            outstanding <= 1'b1;
        else if (res_valid)
            outstanding <= 1'b0;
    end

    credit_held: assert property (@(posedge i_clk) disable iff (!i_reset)
        outstanding |-> !op_valid)
        else $error("op_valid issued while the credit was spent");

    op_pulse: assert property (@(posedge i_clk) disable iff (!i_reset)
        op_valid |=> !op_valid)
        else $error("op_valid longer than one cycle");

    // next issue exactly two cycles after the result
    next_gap_low: assert property (@(posedge i_clk) disable iff (!i_reset)
        $past(res_valid && outstanding) |-> !op_valid)
        else $error("op_valid one cycle after res_valid");

    next_gap_issue: assert property (@(posedge i_clk) disable iff (!i_reset)
        busy && $past(res_valid && outstanding, 2) |-> op_valid)
        else $error("op_valid missing two cycles after res_valid");

    done_pulse: assert property (@(posedge i_clk) disable iff (!i_reset)
        done |=> !done)
        else $error("done longer than one cycle");

endmodule

bind point_mult_top point_mult_assert point_mult_assert_inst (.*);

// File: sim/tb_field_model.svh
`ifndef TB_FIELD_MODEL_SVH
`define TB_FIELD_MODEL_SVH

localparam longint unsigned PRIME = 64'h7fff_ffff;  // 2^31 - 1

function automatic field_t f_add(input field_t a, input field_t b);
    return field_t'((64'(a) + 64'(b)) % PRIME);
endfunction

function automatic field_t f_sub(input field_t a, input field_t b);
    return field_t'((64'(a) + PRIME - 64'(b)) % PRIME);
endfunction

function automatic field_t f_mul(input field_t a, input field_t b);
    return field_t'((64'(a) * 64'(b)) % PRIME);
endfunction

function automatic field_t f_pow(input field_t base, input field_t e);
    field_t r;
    field_t sq;
    int     i;
    r  = 32'd1;
    sq = base;
    for (i = 0; i < 31; i++)
    begin
        if (e[i])
            r = f_mul(r, sq);
        sq = f_mul(sq, sq);
    end
    return r;
endfunction

// inverse by Fermat, b^(p-2)
function automatic field_t f_div(input field_t a, input field_t b);
    return f_mul(a, f_pow(b, field_t'(PRIME - 2)));
endfunction

function automatic field_t field_apply(input op_code_t op, input field_t a, input field_t b);
    case (op)
        OP_ADD:  return f_add(a, b);
        OP_SUB:  return f_sub(a, b);
        OP_MUL:  return f_mul(a, b);
        default: return f_div(a, b);
    endcase
endfunction

function automatic point_t ref_double(input point_t p, input field_t a);
    field_t lam;
    point_t r;
    lam = f_div(f_add(f_mul(32'd3, f_mul(p.x, p.x)), a), f_add(p.y, p.y));
    r.x = f_sub(f_mul(lam, lam), f_add(p.x, p.x));
    r.y = f_sub(f_mul(lam, f_sub(p.x, r.x)), p.y);
    return r;
endfunction

function automatic point_t ref_add(input point_t p, input point_t q);
    field_t lam;
    point_t r;
    lam = f_div(f_sub(q.y, p.y), f_sub(q.x, p.x));
    r.x = f_sub(f_sub(f_mul(lam, lam), p.x), q.x);
    r.y = f_sub(f_mul(lam, f_sub(p.x, r.x)), p.y);
    return r;
endfunction

// left-to-right double-and-add, top key bit assumed set
function automatic point_t ref_mult(input point_t p, input field_t a,
                                   input logic [31:0] k, input int nbits);
    point_t q;
    int     i;
    q = p;
    for (i = nbits - 2; i >= 0; i--)
    begin
        q = ref_double(q, a);
        if (k[i])
            q = ref_add(q, p);
    end
    return q;
endfunction

`endif

// File: sim/tb_point_mult.sv
`timescale 1ns/1ps

module tb_point_mult;
    import ecc_pkg::*;

    `include "tb_field_model.svh"

    localparam int          KEY_BITS  = 8;
    localparam int          NUM_CASES = 5;
    localparam int          TIMEOUT   = 5000;
    localparam int unsigned SEED      = 32'h8e81_bdd4;

    typedef struct packed
    {
        field_t              px;
        field_t              py;
        field_t              a;
        logic [KEY_BITS-1:0] key;
        logic                stray;  // extra start while busy
    } case_t;

    localparam case_t CASES [NUM_CASES] = '{
        '{32'h0123_4567, 32'h0765_4321, 32'h0000_0003, 8'h81, 1'b0},
        '{32'h1a2b_3c4d, 32'h2c3d_4e5f, 32'h7fff_fffc, 8'h80, 1'b0},
        '{32'h3141_5926, 32'h2718_2818, 32'h0000_0007, 8'hb5, 1'b1},
        '{32'h0bad_c0de, 32'h1337_beef, 32'h0000_0000, 8'hff, 1'b0},
        '{32'h5555_1234, 32'h6666_abcd, 32'h0000_0001, 8'hc6, 1'b1}
    };

    logic                i_clk;
    logic                i_reset;
    logic                start;
    logic [KEY_BITS-1:0] key;
    field_t              px;
    field_t              py;
    field_t              curve_a;
    logic                op_valid;
    op_code_t            op_code;
    field_t              op_a;
    field_t              op_b;
    logic                res_valid = 1'b0;
    field_t              res_data  = '0;
    logic                busy;
    logic                done;
    field_t              qx;
    field_t              qy;

    op_code_t exp_op [$];  // predicted operation stream
    field_t   exp_a [$];
    field_t   exp_b [$];

    int     error_count    = 0;
    int     check_count    = 0;
    int     ops_seen       = 0;
    bit     first_op       = 1'b1;
    bit     pending        = 1'b0;
    int     delay_left     = 0;
    field_t pend_res       = '0;
    longint cycle          = 0;
    longint last_res_cycle = 0;
    bit     outstanding    = 1'b0;
    bit     done_q         = 1'b0;

    point_mult_top #(.KEY_BITS(KEY_BITS)) point_mult_top_inst
    (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .start     (start),
        .key       (key),
        .px        (px),
        .py        (py),
        .curve_a   (curve_a),
        .op_valid  (op_valid),
        .op_code   (op_code),
        .op_a      (op_a),
        .op_b      (op_b),
        .res_valid (res_valid),
        .res_data  (res_data),
        .busy      (busy),
        .done      (done),
        .qx        (qx),
        .qy        (qy)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    function automatic void report_mismatch(input string name, input logic [31:0] exp_v,
                                            input logic [31:0] act_v);
        $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
        error_count++;
    endfunction

    function automatic void report_failure(input string what);
        $display("error at %0t ns: %s", $time, what);
        error_count++;
    endfunction

    function automatic void compare(input string name, input logic [31:0] exp_v,
                                    input logic [31:0] act_v);
        check_count++;
        if (act_v !== exp_v)
            report_mismatch(name, exp_v, act_v);
    endfunction

    function automatic field_t predict_op(input op_code_t op, input field_t a, input field_t b);
        exp_op.push_back(op);
        exp_a.push_back(a);
        exp_b.push_back(b);
        if (op == OP_DIV && b == '0)
            report_failure("table row hits a degenerate case, division by zero");
        return field_apply(op, a, b);
    endfunction

    // walk the doubling and addition sequences one operation at a time
    function automatic void build_expected(input case_t c);
        field_t x;
        field_t y;
        field_t t;
        field_t u;
        field_t l;
        field_t x3;
        int     i;
        x = c.px;
        y = c.py;
        for (i = KEY_BITS - 2; i >= 0; i--)
        begin
            t  = predict_op(OP_MUL, x, x);
            u  = predict_op(OP_ADD, t, t);
            t  = predict_op(OP_ADD, u, t);
            t  = predict_op(OP_ADD, t, c.a);
            u  = predict_op(OP_ADD, y, y);
            l  = predict_op(OP_DIV, t, u);
            t  = predict_op(OP_MUL, l, l);
            t  = predict_op(OP_SUB, t, x);
            x3 = predict_op(OP_SUB, t, x);
            u  = predict_op(OP_SUB, x, x3);
            u  = predict_op(OP_MUL, l, u);
            y  = predict_op(OP_SUB, u, y);
            x  = x3;
            if (c.key[i])
            begin
                t  = predict_op(OP_SUB, c.px, x);
                u  = predict_op(OP_SUB, c.py, y);
                l  = predict_op(OP_DIV, u, t);
                t  = predict_op(OP_MUL, l, l);
                t  = predict_op(OP_SUB, t, x);
                x3 = predict_op(OP_SUB, t, c.px);
                u  = predict_op(OP_SUB, x, x3);
                u  = predict_op(OP_MUL, l, u);
                y  = predict_op(OP_SUB, u, y);
                x  = x3;
            end
        end
    endfunction

    // arithmetic unit with 1 to 8 cycles of latency
    always @(posedge i_clk)
    begin
        res_valid <= 1'b0;
        if (op_valid)
        begin
            pend_res   = field_apply(op_code, op_a, op_b);
            delay_left = $urandom_range(8, 1);
            pending    = 1'b1;
        end
        if (pending)
        begin
            delay_left--;
            if (delay_left == 0)
            begin
                res_valid <= 1'b1;
                res_data  <= pend_res;
                pending    = 1'b0;
            end
        end
    end

    always @(posedge i_clk)
    begin
        op_code_t e_op;
        field_t   e_a;
        field_t   e_b;
        cycle++;
        if (i_reset)
        begin
            if (op_valid)
            begin
                if (outstanding)
                    report_failure("op_valid rose again before res_valid returned the credit");
                if (!first_op && cycle != last_res_cycle + 2)
                    report_failure("op_valid did not come two cycles after res_valid");
                if (exp_op.size() == 0)
                begin
                    report_failure("operation issued beyond the predicted sequence");
                end
                else
                begin
                    e_op = exp_op.pop_front();
                    e_a  = exp_a.pop_front();
                    e_b  = exp_b.pop_front();
                    compare("op_code", 32'(e_op), 32'(op_code));
                    compare("op_a", e_a, op_a);
                    compare("op_b", e_b, op_b);
                end
                outstanding = 1'b1;
                first_op    = 1'b0;
                ops_seen++;
            end
            else if (res_valid && outstanding)
            begin
                outstanding    = 1'b0;
                last_res_cycle = cycle;
            end
            if (done)
            begin
                if (cycle != last_res_cycle + 1)
                    report_failure("done did not come one cycle after the last res_valid");
                if (busy)
                    report_failure("busy still high in the done cycle");
            end
            if (done && done_q)
                report_failure("done held high for more than one cycle");
            done_q = done;
        end
    end

    task automatic wait_for_done(output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < TIMEOUT)
        begin
            @(posedge i_clk);
            ok = done;
            n++;
        end
    endtask

    task automatic wait_for_ops(input int count, output bit ok);
        int n;
        int seen;
        n    = 0;
        seen = 0;
        while (seen < count && n < TIMEOUT)
        begin
            @(posedge i_clk);
            if (op_valid)
                seen++;
            n++;
        end
        ok = (seen == count);
    endtask

    initial
    begin
        case_t  cur;
        point_t ref_q;
        bit     ok;
        bit     aborted;
        int     i;
        int     exp_count;
        void'($urandom(SEED));
        aborted   = 1'b0;
        i_reset <= 1'b0;
        start   <= 1'b0;
        key     <= '0;
        px      <= '0;
        py      <= '0;
        curve_a <= '0;
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b1;
        @(posedge i_clk);
        compare("op_valid", 32'd0, 32'(op_valid));  // idle after reset
        compare("busy", 32'd0, 32'(busy));
        compare("done", 32'd0, 32'(done));

        for (i = 0; i < NUM_CASES && !aborted; i++)
        begin
            cur   = CASES[i];
            ref_q = ref_mult('{x: cur.px, y: cur.py}, cur.a, 32'(cur.key), KEY_BITS);
            exp_op.delete();
            exp_a.delete();
            exp_b.delete();
            build_expected(cur);
            exp_count = 12 * (KEY_BITS - 1) + 9 * $countones(cur.key[KEY_BITS-2:0]);
            ops_seen  = 0;
            first_op  = 1'b1;
            @(posedge i_clk);
            start   <= 1'b1;
            key     <= cur.key;
            px      <= cur.px;
            py      <= cur.py;
            curve_a <= cur.a;
            @(posedge i_clk);
            start <= 1'b0;
            if (cur.stray)
            begin
                wait_for_ops(3, ok);
                if (!ok)
                begin
                    report_failure("timeout waiting for the first operations of a case");
                    aborted = 1'b1;
                end
                else
                begin
                    start <= 1'b1;  // must be ignored
                    key   <= {1'b1, ~cur.key[KEY_BITS-2:0]};
                    px    <= cur.px ^ 32'h0000_5555;
                    @(posedge i_clk);
                    start <= 1'b0;
                    key   <= cur.key;
                    px    <= cur.px;
                end
            end
            if (!aborted)
            begin
                wait_for_done(ok);
                if (!ok)
                begin
                    report_failure("timeout waiting for done");
                    aborted = 1'b1;
                end
                else
                begin
                    compare("qx", ref_q.x, qx);
                    compare("qy", ref_q.y, qy);
                    compare("operation count", 32'(exp_count), 32'(ops_seen));
                    if (exp_op.size() != 0)
                        report_failure("fewer operations issued than predicted");
                    repeat (3) @(posedge i_clk);
                    compare("qx held", ref_q.x, qx);
                    compare("qy held", ref_q.y, qy);
                end
            end
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+sim
hdl/ecc_pkg.sv
hdl/field_op_if.sv
hdl/key_scanner.sv
hdl/point_op_sequencer.sv
hdl/op_credit_port.sv
hdl/point_mult_top.sv
sim/point_mult_assert.sv
sim/tb_point_mult.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_point_mult -f tb.f
	@out="$$(./obj_dir/Vtb_point_mult)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
